// File: src/rv_pkg.sv
package rv_pkg;

    localparam int XLEN = 32;

    // Base opcodes
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;

    // ALU op from the decoder
    localparam logic [1:0] ALU_ADD    = 2'b00;
    localparam logic [1:0] ALU_BRANCH = 2'b01; // Compare by funct3
    localparam logic [1:0] ALU_FUNCT  = 2'b10; // Operation from funct3 and funct7
    localparam logic [1:0] ALU_PASS_B = 2'b11;

    // Immediate formats
    localparam logic [2:0] IMM_I     = 3'b000;
    localparam logic [2:0] IMM_S     = 3'b001;
    localparam logic [2:0] IMM_B     = 3'b010;
    localparam logic [2:0] IMM_U     = 3'b011;
    localparam logic [2:0] IMM_J     = 3'b100;
    localparam logic [2:0] IMM_SHAMT = 3'b101; // Zero-extended shift amount

    // Writeback source
    localparam logic [1:0] RES_ALU  = 2'b00;
    localparam logic [1:0] RES_MEM  = 2'b01;
    localparam logic [1:0] RES_LINK = 2'b10; // pc + 4 for JAL and JALR

    localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;

endpackage

// File: src/main_decoder.sv
`timescale 1ns/1ps

module main_decoder (
    input  logic [6:0] opcode_i,
    input  logic [2:0] funct3_i,
    input  logic [6:0] funct7_i,

    output logic       reg_wr_en_o,
    output logic       mem_wr_en_o,
    output logic [2:0] imm_src_o,
    output logic       alu_src_o,       // Operand B is the immediate
    output logic       alu_src_a_sel_o, // Operand A is the pc
    output logic [1:0] alu_op_o,
    output logic       branch_o,
    output logic       jump_o,
    output logic [1:0] result_src_o,
    output logic [3:0] byte_en_o,
    output logic       load_signed_o    // Sign-extend loaded data
);

    logic funct7_zero;
    logic funct7_alt;

    assign funct7_zero = (funct7_i == 7'h00);
    assign funct7_alt  = (funct7_i == 7'h20); // SUB and SRA encodings

    always_comb begin
        // Everything inactive unless an opcode claims it
        reg_wr_en_o     = 1'b0;
        mem_wr_en_o     = 1'b0;
        imm_src_o       = rv_pkg::IMM_I;
        alu_src_o       = 1'b0;
        alu_src_a_sel_o = 1'b0;
        alu_op_o        = rv_pkg::ALU_ADD;
        branch_o        = 1'b0;
        jump_o          = 1'b0;
        result_src_o    = rv_pkg::RES_ALU;
        byte_en_o       = 4'b0000;
        load_signed_o   = 1'b0;

        case (opcode_i)
            rv_pkg::OP_LOAD: begin
                alu_src_o     = 1'b1;
                result_src_o  = rv_pkg::RES_MEM;
                reg_wr_en_o   = 1'b1;
                load_signed_o = ~funct3_i[2]; // LB and LH
                case (funct3_i)
                    3'h0, 3'h4: byte_en_o = 4'b0001;
                    3'h1, 3'h5: byte_en_o = 4'b0011;
                    3'h2:       byte_en_o = 4'b1111;
                    default: begin
                        reg_wr_en_o   = 1'b0; // Reserved width
                        load_signed_o = 1'b0;
                    end
                endcase
            end

            rv_pkg::OP_STORE: begin
                imm_src_o = rv_pkg::IMM_S;
                alu_src_o = 1'b1;
                case (funct3_i)
                    3'h0:    byte_en_o = 4'b0001; // SB
                    3'h1:    byte_en_o = 4'b0011; // SH
                    3'h2:    byte_en_o = 4'b1111; // SW
                    default: byte_en_o = 4'b0000;
                endcase
                mem_wr_en_o = (byte_en_o != 4'b0000);
            end

            rv_pkg::OP_IMM: begin
                alu_src_o = 1'b1;
                alu_op_o  = rv_pkg::ALU_FUNCT;
                if (funct3_i == 3'h1) begin
                    imm_src_o   = rv_pkg::IMM_SHAMT;
                    reg_wr_en_o = funct7_zero;
                end else if (funct3_i == 3'h5) begin
                    imm_src_o   = rv_pkg::IMM_SHAMT;
                    reg_wr_en_o = funct7_zero | funct7_alt;
                end else begin
                    reg_wr_en_o = 1'b1;
                end
            end

            rv_pkg::OP_REG: begin
                alu_op_o    = rv_pkg::ALU_FUNCT;
                reg_wr_en_o = funct7_zero |
                              (funct7_alt & ((funct3_i == 3'h0) | (funct3_i == 3'h5)));
            end

            rv_pkg::OP_BRANCH: begin
                imm_src_o = rv_pkg::IMM_B;
                alu_op_o  = rv_pkg::ALU_BRANCH;
                branch_o  = 1'b1;
            end

            rv_pkg::OP_JAL: begin
                imm_src_o       = rv_pkg::IMM_J;
                alu_src_o       = 1'b1;
                alu_src_a_sel_o = 1'b1; // Target is pc + offset
                jump_o          = 1'b1;
                result_src_o    = rv_pkg::RES_LINK;
                reg_wr_en_o     = 1'b1;
            end

            rv_pkg::OP_JALR: begin
                alu_src_o    = 1'b1;
                jump_o       = 1'b1;
                result_src_o = rv_pkg::RES_LINK;
                reg_wr_en_o  = 1'b1;
            end

            rv_pkg::OP_LUI: begin
                imm_src_o   = rv_pkg::IMM_U;
                alu_src_o   = 1'b1;
                alu_op_o    = rv_pkg::ALU_PASS_B;
                reg_wr_en_o = 1'b1;
            end

            rv_pkg::OP_AUIPC: begin
                imm_src_o       = rv_pkg::IMM_U;
                alu_src_o       = 1'b1;
                alu_src_a_sel_o = 1'b1;
                reg_wr_en_o     = 1'b1;
            end

            default: begin
                reg_wr_en_o = 1'b0; // Unknown opcode leaves the defaults
            end
        endcase
    end

endmodule

// File: src/imm_gen.sv
`timescale 1ns/1ps

module imm_gen (
    input  logic [31:0]             instr_i,
    input  logic [2:0]              imm_src_i,
    output logic [rv_pkg::XLEN-1:0] imm_o
);

    logic sign;

    assign sign = instr_i[31];

    always_comb begin
        case (imm_src_i)
            rv_pkg::IMM_I:
                imm_o = {{20{sign}}, instr_i[31:20]};
            rv_pkg::IMM_S:
                imm_o = {{20{sign}}, instr_i[31:25], instr_i[11:7]};
            // Branch offset with implicit zero lsb
            rv_pkg::IMM_B:
                imm_o = {{19{sign}}, sign, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
            rv_pkg::IMM_U:
                imm_o = {instr_i[31:12], 12'h000};
            rv_pkg::IMM_J:
                imm_o = {{11{sign}}, sign, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};
            rv_pkg::IMM_SHAMT:
                imm_o = {27'd0, instr_i[24:20]}; // Upper bits hold funct7
            default:
                imm_o = '0;
        endcase
    end

endmodule

// File: src/alu.sv
`timescale 1ns/1ps

module alu (
    input  logic [rv_pkg::XLEN-1:0] rs1_data_i,
    input  logic [rv_pkg::XLEN-1:0] rs2_data_i,
    input  logic [rv_pkg::XLEN-1:0] pc_i,
    input  logic [rv_pkg::XLEN-1:0] imm_i,
    input  logic                    alu_src_i,
    input  logic                    alu_src_a_sel_i,
    input  logic [1:0]              alu_op_i,
    input  logic [2:0]              funct3_i,
    input  logic [6:0]              funct7_i,
    input  logic                    is_reg_op_i, // Opcode bit 5, R-type
    output logic [rv_pkg::XLEN-1:0] result_o,
    output logic                    branch_taken_o
);

    logic [rv_pkg::XLEN-1:0] op_a;
    logic [rv_pkg::XLEN-1:0] op_b;
    logic [4:0]              shamt;
    logic                    alt;
    logic                    lt_s;
    logic                    lt_u;

    assign op_a  = alu_src_a_sel_i ? pc_i : rs1_data_i;
    assign op_b  = alu_src_i ? imm_i : rs2_data_i;
    assign shamt = op_b[4:0];
    assign alt   = (funct7_i == 7'h20);
    assign lt_s  = ($signed(op_a) < $signed(op_b));
    assign lt_u  = (op_a < op_b);

    always_comb begin
        result_o       = op_a + op_b;
        branch_taken_o = 1'b0;
        case (alu_op_i)
            rv_pkg::ALU_PASS_B: result_o = op_b; // LUI
            rv_pkg::ALU_BRANCH: begin
                result_o = op_a - op_b;
                case (funct3_i)
                    3'h0:    branch_taken_o = (op_a == op_b);
                    3'h1:    branch_taken_o = (op_a != op_b);
                    3'h4:    branch_taken_o = lt_s;
                    3'h5:    branch_taken_o = ~lt_s;
                    3'h6:    branch_taken_o = lt_u;
                    3'h7:    branch_taken_o = ~lt_u;
                    default: branch_taken_o = 1'b0;
                endcase
            end
            rv_pkg::ALU_FUNCT: begin
                case (funct3_i)
                    // SUB only exists in R-type
                    3'h0:    result_o = (is_reg_op_i && alt) ? op_a - op_b : op_a + op_b;
                    3'h1:    result_o = op_a << shamt;
                    3'h2:    result_o = {31'd0, lt_s};
                    3'h3:    result_o = {31'd0, lt_u};
                    3'h4:    result_o = op_a ^ op_b;
                    3'h5:    result_o = alt ? $unsigned($signed(op_a) >>> shamt) : op_a >> shamt;
                    3'h6:    result_o = op_a | op_b;
                    default: result_o = op_a & op_b;
                endcase
            end
            default: result_o = op_a + op_b;
        endcase
    end

endmodule

// File: src/reg_file.sv
`timescale 1ns/1ps

module reg_file (
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  logic [4:0]              rs1_addr_i,
    input  logic [4:0]              rs2_addr_i,
    input  logic [4:0]              rd_addr_i,
    input  logic                    rd_we_i,
    input  logic [rv_pkg::XLEN-1:0] rd_wdata_i,
    output logic [rv_pkg::XLEN-1:0] rs1_data_o,
    output logic [rv_pkg::XLEN-1:0] rs2_data_o
);

    logic [rv_pkg::XLEN-1:0] regs [32];

    always_ff @(posedge clk_i) begin
        if (rd_we_i && (rd_addr_i != 5'd0)) begin
            regs[rd_addr_i] <= rd_wdata_i;
        end
    end

    // x0 reads as zero whatever the array holds
    assign rs1_data_o = (rs1_addr_i == 5'd0) ? '0 : regs[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == 5'd0) ? '0 : regs[rs2_addr_i];

    // Write enable comes through decoder and commit stage
    a_rd_we_known: assert property (
        @(posedge clk_i) disable iff (rst_i) !$isunknown(rd_we_i)
    ) else $error("rd_we_i is unknown");

endmodule

// File: src/commit_unit.sv
`timescale 1ns/1ps

module commit_unit (
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  logic [rv_pkg::XLEN-1:0] alu_result_i,
    input  logic [rv_pkg::XLEN-1:0] imm_i,
    input  logic [rv_pkg::XLEN-1:0] rs2_data_i,
    input  logic                    branch_taken_i,
    input  logic                    branch_i,
    input  logic                    jump_i,
    input  logic                    mem_wr_en_i,
    input  logic                    reg_wr_en_i,
    input  logic [3:0]              byte_en_i,
    input  logic                    load_signed_i,
    input  logic [1:0]              result_src_i,
    input  logic [rv_pkg::XLEN-1:0] dmem_rdata_i,
    output logic [rv_pkg::XLEN-1:0] pc_o,
    output logic [rv_pkg::XLEN-1:0] dmem_addr_o,
    output logic [rv_pkg::XLEN-1:0] dmem_wdata_o,
    output logic [3:0]              dmem_be_o,
    output logic                    dmem_we_o,
    output logic                    rd_we_o,
    output logic [rv_pkg::XLEN-1:0] rd_wdata_o
);

    logic [rv_pkg::XLEN-1:0] pc_q;
    logic [rv_pkg::XLEN-1:0] pc_plus4;
    logic [rv_pkg::XLEN-1:0] pc_next;
    logic [1:0]              byte_off;
    logic [rv_pkg::XLEN-1:0] rdata_shifted;
    logic [rv_pkg::XLEN-1:0] load_data;

    assign pc_plus4 = pc_q + 32'd4;

    // Jump wins over a taken branch
    always_comb begin
        if (jump_i) begin
            pc_next = {alu_result_i[rv_pkg::XLEN-1:1], 1'b0};
        end else if (branch_i && branch_taken_i) begin
            pc_next = pc_q + imm_i;
        end else begin
            pc_next = pc_plus4;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pc_q <= rv_pkg::RESET_PC;
        end else begin
            pc_q <= pc_next;
        end
    end

    assign pc_o = pc_q;

    // Word address out, byte lanes from the low bits
    assign byte_off     = alu_result_i[1:0];
    assign dmem_addr_o  = {alu_result_i[rv_pkg::XLEN-1:2], 2'b00};
    assign dmem_wdata_o = rs2_data_i << {byte_off, 3'b000};
    assign dmem_be_o    = byte_en_i << byte_off;
    assign dmem_we_o    = mem_wr_en_i & ~rst_i;

    assign rdata_shifted = dmem_rdata_i >> {byte_off, 3'b000};

    always_comb begin
        case (byte_en_i)
            4'b0001: load_data = {{24{load_signed_i & rdata_shifted[7]}}, rdata_shifted[7:0]};
            4'b0011: load_data = {{16{load_signed_i & rdata_shifted[15]}}, rdata_shifted[15:0]};
            default: load_data = rdata_shifted; // Full word
        endcase
    end

    always_comb begin
        case (result_src_i)
            rv_pkg::RES_MEM:  rd_wdata_o = load_data;
            rv_pkg::RES_LINK: rd_wdata_o = pc_plus4;
            default:          rd_wdata_o = alu_result_i;
        endcase
    end

    assign rd_we_o = reg_wr_en_i & ~rst_i;

    // A store must touch at least one lane
    a_store_has_lanes: assert property (
        @(posedge clk_i) disable iff (rst_i) dmem_we_o |-> (dmem_be_o != 4'b0000)
    ) else $error("store with empty byte enables");

    a_pc_aligned: assert property (
        @(posedge clk_i) disable iff (rst_i) pc_o[1:0] == 2'b00
    ) else $error("pc not word aligned");

endmodule

// File: src/rv_core.sv
`timescale 1ns/1ps

module rv_core (
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  logic [31:0]             instr_i,
    input  logic [rv_pkg::XLEN-1:0] dmem_rdata_i,
    output logic [rv_pkg::XLEN-1:0] pc_o,
    output logic [rv_pkg::XLEN-1:0] dmem_addr_o,
    output logic [rv_pkg::XLEN-1:0] dmem_wdata_o,
    output logic [3:0]              dmem_be_o,
    output logic                    dmem_we_o
);

    // Instruction fields
    logic [6:0] opcode;
    logic [4:0] rd_addr;
    logic [2:0] funct3;
    logic [4:0] rs1_addr;
    logic [4:0] rs2_addr;
    logic [6:0] funct7;

    assign opcode   = instr_i[6:0];
    assign rd_addr  = instr_i[11:7];
    assign funct3   = instr_i[14:12];
    assign rs1_addr = instr_i[19:15];
    assign rs2_addr = instr_i[24:20];
    assign funct7   = instr_i[31:25];

    logic                    reg_wr_en, mem_wr_en, alu_src, alu_src_a_sel;
    logic                    branch, jump, load_signed, branch_taken, rd_we;
    logic [2:0]              imm_src;
    logic [1:0]              alu_op, result_src;
    logic [3:0]              byte_en;
    logic [rv_pkg::XLEN-1:0] imm, rs1_data, rs2_data, alu_result, rd_wdata;

    main_decoder i_main_decoder (
        .opcode_i(opcode), .funct3_i(funct3), .funct7_i(funct7),
        .reg_wr_en_o(reg_wr_en), .mem_wr_en_o(mem_wr_en), .imm_src_o(imm_src),
        .alu_src_o(alu_src), .alu_src_a_sel_o(alu_src_a_sel), .alu_op_o(alu_op),
        .branch_o(branch), .jump_o(jump), .result_src_o(result_src),
        .byte_en_o(byte_en), .load_signed_o(load_signed)
    );

    imm_gen i_imm_gen (.instr_i(instr_i), .imm_src_i(imm_src), .imm_o(imm));

    alu i_alu (
        .rs1_data_i(rs1_data), .rs2_data_i(rs2_data), .pc_i(pc_o), .imm_i(imm),
        .alu_src_i(alu_src), .alu_src_a_sel_i(alu_src_a_sel), .alu_op_i(alu_op),
        .funct3_i(funct3), .funct7_i(funct7), .is_reg_op_i(opcode[5]),
        .result_o(alu_result), .branch_taken_o(branch_taken)
    );

    reg_file i_reg_file (
        .clk_i(clk_i), .rst_i(rst_i), .rs1_addr_i(rs1_addr), .rs2_addr_i(rs2_addr),
        .rd_addr_i(rd_addr), .rd_we_i(rd_we), .rd_wdata_i(rd_wdata),
        .rs1_data_o(rs1_data), .rs2_data_o(rs2_data)
    );

    commit_unit i_commit_unit (
        .clk_i(clk_i), .rst_i(rst_i), .alu_result_i(alu_result), .imm_i(imm),
        .rs2_data_i(rs2_data), .branch_taken_i(branch_taken), .branch_i(branch),
        .jump_i(jump), .mem_wr_en_i(mem_wr_en), .reg_wr_en_i(reg_wr_en),
        .byte_en_i(byte_en), .load_signed_i(load_signed), .result_src_i(result_src),
        .dmem_rdata_i(dmem_rdata_i), .pc_o(pc_o), .dmem_addr_o(dmem_addr_o),
        .dmem_wdata_o(dmem_wdata_o), .dmem_be_o(dmem_be_o), .dmem_we_o(dmem_we_o),
        .rd_we_o(rd_we), .rd_wdata_o(rd_wdata)
    );

endmodule

// File: verif/tb_rv_core.sv
`timescale 1ns/1ps

module tb_rv_core;

    logic        clk = 1'b0;
    logic        rst;
    logic [31:0] instr;
    logic [31:0] dmem_rdata;
    logic [31:0] pc;
    logic [31:0] dmem_addr;
    logic [31:0] dmem_wdata;
    logic [3:0]  dmem_be;
    logic        dmem_we;

    logic [31:0] imem [256];
    logic [31:0] dmem [256];
    logic [31:0] expect_q [$]; // Result slots from 0x200 upward
    logic [31:0] exp_pc [$];
    logic [31:0] pc_trace [$];
    int unsigned prog_len;
    logic [31:0] end_pc;
    integer      seed;

    always #5 clk = ~clk;

    // Fetch for the current pc
    always @(posedge clk) begin
        #1;
        instr = imem[pc[9:2]];
    end

    assign dmem_rdata = dmem[dmem_addr[9:2]]; // Combinational read

    always @(posedge clk) begin
        if (dmem_we) begin
            for (int b = 0; b < 4; b++) begin
                if (dmem_be[b]) dmem[dmem_addr[9:2]][8*b +: 8] <= dmem_wdata[8*b +: 8];
            end
        end
    end

    rv_core i_dut (
        .clk_i(clk), .rst_i(rst), .instr_i(instr), .dmem_rdata_i(dmem_rdata),
        .pc_o(pc), .dmem_addr_o(dmem_addr), .dmem_wdata_o(dmem_wdata),
        .dmem_be_o(dmem_be), .dmem_we_o(dmem_we)
    );

    function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                          logic [4:0] rd, logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_r(logic alt, logic [4:0] rs2, rs1, logic [2:0] f3,
                                          logic [4:0] rd);
        return {1'b0, alt, 5'd0, rs2, rs1, f3, rd, rv_pkg::OP_REG};
    endfunction

    function automatic logic [31:0] enc_s(logic [11:0] imm, logic [4:0] rs2, rs1,
                                          logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], rv_pkg::OP_STORE};
    endfunction

    function automatic logic [31:0] enc_b(logic [12:0] imm, logic [4:0] rs2, rs1,
                                          logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv_pkg::OP_BRANCH};
    endfunction

    function automatic logic [31:0] enc_u(logic [19:0] imm, logic [4:0] rd, logic [6:0] op);
        return {imm, rd, op};
    endfunction

    function automatic logic [31:0] enc_j(logic [20:0] imm, logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_pkg::OP_JAL};
    endfunction

    // Signed less-than from the sign bits, then magnitude
    function automatic logic less_signed(logic [31:0] a, b);
        return (a[31] != b[31]) ? a[31] : (a < b);
    endfunction

    function automatic logic [31:0] arith_model(logic [2:0] f3, logic alt, logic [31:0] a, b);
        case (f3)
            3'h0: return alt ? a - b : a + b;
            3'h1: return a << b[4:0];
            3'h2: return {31'd0, less_signed(a, b)};
            3'h3: return {31'd0, a < b};
            3'h4: return a ^ b;
            3'h5: return (a >> b[4:0]) | (~(32'hffff_ffff >> b[4:0]) & {32{alt & a[31]}});
            3'h6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_model(logic [2:0] f3, logic [31:0] a, b);
        case (f3)
            3'h0: return a == b;
            3'h1: return a != b;
            3'h4: return less_signed(a, b);
            3'h5: return !less_signed(a, b);
            3'h6: return a < b;
            default: return a >= b;
        endcase
    endfunction

    task automatic abort_run(string why);
        $display("sim failed");
        $fatal(1, "%s", why);
    endtask

    task automatic check_value(logic [31:0] got, logic [31:0] exp, string what);
        assert (got === exp) else begin
            $display("Mismatch at %0t: %s, got %08h expected %08h", $time, what, got, exp);
            abort_run(what);
        end
    endtask

    task automatic new_program();
        for (int i = 0; i < 256; i++) begin
            imem[i] = enc_i(12'(i), 5'd0, 3'h0, 5'd0, rv_pkg::OP_IMM); // NOP tagged by index
            dmem[i] = 32'h9e37_79b9 * (i + 1);
        end
        prog_len = 0;
        expect_q.delete();
        exp_pc.delete();
        pc_trace.delete();
        exp_pc.push_back(rv_pkg::RESET_PC);
    endtask

    task automatic emit(logic [31:0] word);
        imem[prog_len] = word;
        prog_len++;
    endtask

    // Straight-line instruction
    task automatic emit_seq(logic [31:0] word);
        emit(word);
        exp_pc.push_back(4 * prog_len);
    endtask

    task automatic store_result(logic [4:0] rs, logic [31:0] exp);
        emit_seq(enc_s(12'h200 + 12'(4 * expect_q.size()), rs, 5'd0, 3'h2));
        expect_q.push_back(exp);
    endtask

    task automatic finish_program();
        end_pc = 4 * prog_len;
        emit(enc_j(21'd0, 5'd0)); // Self loop
    endtask

    task automatic pulse_reset();
        @(posedge clk);
        #1;
        rst = 1'b1;
        for (int i = 0; i < 16; i++) begin
            @(posedge clk);
            #1;
            if (i == 15) rst = 1'b0;
            #3;
            check_value(pc, rv_pkg::RESET_PC, "pc around reset");
            if (i < 15) check_value({31'd0, dmem_we}, 32'd0, "store enable in reset");
        end
    endtask

    task automatic run_program();
        int cycles;
        pulse_reset();
        pc_trace.push_back(pc);
        cycles = 0;
        while (pc !== end_pc) begin
            if (cycles == 200) begin
                $display("Timeout: pc never reached the end of the program at %08h", end_pc);
                abort_run("program did not finish");
            end
            @(posedge clk);
            #4;
            pc_trace.push_back(pc);
            cycles++;
        end
    endtask

    task automatic check_results(string test);
        for (int i = 0; i < expect_q.size(); i++) begin
            check_value(dmem[128 + i], expect_q[i], $sformatf("%s result %0d", test, i));
        end
    endtask

    task automatic check_trace(string test);
        check_value(pc_trace.size(), exp_pc.size(), {test, " trace length"});
        for (int i = 0; i < exp_pc.size(); i++) begin
            check_value(pc_trace[i], exp_pc[i], $sformatf("%s pc at cycle %0d", test, i));
        end
    endtask

    task automatic test_reset();
        new_program();
        store_result(5'd0, 32'd0); // Store sits at pc 0 for all of reset
        for (int i = 0; i < 8; i++) begin
            emit_seq(enc_i(12'(i + 1), 5'(i), 3'h0, 5'(i + 1), rv_pkg::OP_IMM));
        end
        finish_program();
        run_program();
        check_trace("reset");
        check_results("reset");
    endtask

    task automatic test_arith();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        new_program();
        a = $random(seed);
        b = $random(seed);
        dmem[64] = a;
        dmem[65] = b;
        emit_seq(enc_i(12'h100, 5'd0, 3'h2, 5'd1, rv_pkg::OP_LOAD));
        emit_seq(enc_i(12'h104, 5'd0, 3'h2, 5'd2, rv_pkg::OP_LOAD));
        for (int f3 = 0; f3 < 8; f3++) begin
            for (int alt = 0; alt < 2; alt++) begin
                if (alt == 1 && f3 != 0 && f3 != 5) continue;
                emit_seq(enc_r(alt[0], 5'd2, 5'd1, 3'(f3), 5'd3));
                store_result(5'd3, arith_model(3'(f3), alt[0], a, b));
                if (alt == 1 && f3 == 0) continue; // No SUBI
                imm = $random(seed);
                if (f3 == 1 || f3 == 5) imm = {20'd0, 1'b0, alt[0], 5'd0, imm[4:0]};
                else imm = {{20{imm[11]}}, imm[11:0]};
                emit_seq(enc_i(imm[11:0], 5'd1, 3'(f3), 5'd4, rv_pkg::OP_IMM));
                store_result(5'd4, arith_model(3'(f3), alt[0], a, imm));
            end
        end
        emit_seq(enc_i(12'h005, 5'd1, 3'h0, 5'd0, rv_pkg::OP_IMM)); // Write to x0
        store_result(5'd0, 32'd0);
        finish_program();
        run_program();
        check_results("arith");
    endtask

    task automatic load_and_store(logic [2:0] f3, int off, logic [31:0] exp);
        emit_seq(enc_i(12'h100 + 12'(off), 5'd0, f3, 5'd3, rv_pkg::OP_LOAD));
        store_result(5'd3, exp);
    endtask

    task automatic test_loads();
        logic [31:0] w;
        logic [31:0] lane;
        new_program();
        w = 32'hc3e1_7a85; // Mix of negative and positive bytes and halves
        dmem[64] = w;
        for (int off = 0; off < 4; off++) begin
            lane = w >> (8 * off);
            load_and_store(3'h0, off, {{24{lane[7]}}, lane[7:0]});
            load_and_store(3'h4, off, {24'd0, lane[7:0]});
            if (off % 2 == 0) begin
                load_and_store(3'h1, off, {{16{lane[15]}}, lane[15:0]});
                load_and_store(3'h5, off, {16'd0, lane[15:0]});
            end
            if (off == 0) load_and_store(3'h2, off, w);
        end
        finish_program();
        run_program();
        check_results("loads");
    endtask

    task automatic test_stores();
        logic [31:0] v;
        logic [31:0] exp_mem [10]; // Words 0x17c to 0x1a0
        new_program();
        v = $random(seed);
        dmem[64] = v;
        emit_seq(enc_i(12'h100, 5'd0, 3'h2, 5'd1, rv_pkg::OP_LOAD));
        for (int k = 0; k < 4; k++) begin
            emit_seq(enc_s(12'h180 + 12'(5 * k), 5'd1, 5'd0, 3'h0)); // Lane k of word 0x180+4k
        end
        for (int j = 0; j < 2; j++) begin
            emit_seq(enc_s(12'h190 + 12'(6 * j), 5'd1, 5'd0, 3'h1));
        end
        emit_seq(enc_s(12'h198, 5'd1, 5'd0, 3'h2));
        finish_program();
        for (int i = 0; i < 10; i++) exp_mem[i] = dmem[95 + i];
        for (int k = 0; k < 4; k++) exp_mem[1 + k][8*k +: 8] = v[7:0];
        for (int j = 0; j < 2; j++) exp_mem[5 + j][16*j +: 16] = v[15:0];
        exp_mem[7] = v;
        run_program();
        for (int i = 0; i < 10; i++) begin
            check_value(dmem[95 + i], exp_mem[i], $sformatf("stores word %0d", i));
        end
    endtask

    function automatic logic [31:0] init_val(logic [4:0] r);
        return (r == 5'd2) ? 32'hffff_fffd : 32'd5;
    endfunction

    task automatic test_control();
        logic [2:0]  f3;
        logic [4:0]  ra;
        logic [4:0]  rb;
        logic        taken;
        logic [31:0] bpc;
        logic [31:0] jal_pc;
        logic [31:0] jalr_pc;
        new_program();
        emit_seq(enc_i(12'h005, 5'd0, 3'h0, 5'd1, rv_pkg::OP_IMM));
        emit_seq(enc_i(12'hffd, 5'd0, 3'h0, 5'd2, rv_pkg::OP_IMM));
        emit_seq(enc_i(12'h005, 5'd0, 3'h0, 5'd3, rv_pkg::OP_IMM));
        // Three operand pairs per branch and a filler that a taken branch skips
        for (int c = 0; c < 18; c++) begin
            f3 = 3'((c / 3 < 2) ? c / 3 : c / 3 + 2);
            ra = (c % 3 == 2) ? 5'd2 : 5'd1;
            rb = 5'(3 - c % 3);
            bpc = 4 * prog_len;
            taken = branch_model(f3, init_val(ra), init_val(rb));
            emit(enc_b(13'd8, rb, ra, f3));
            exp_pc.push_back(taken ? bpc + 8 : bpc + 4);
            emit(enc_i(12'(c), 5'd0, 3'h0, 5'd0, rv_pkg::OP_IMM));
            if (!taken) exp_pc.push_back(bpc + 8);
        end
        jal_pc = 4 * prog_len;
        emit(enc_j(21'd8, 5'd5));
        exp_pc.push_back(jal_pc + 8);
        emit(enc_i(12'h0, 5'd0, 3'h0, 5'd0, rv_pkg::OP_IMM));
        emit_seq(enc_u(20'd0, 5'd6, rv_pkg::OP_AUIPC));
        jalr_pc = 4 * prog_len;
        emit(enc_i(12'd13, 5'd6, 3'h0, 5'd7, rv_pkg::OP_JALR)); // Odd target with bit 0 dropped
        exp_pc.push_back((jalr_pc - 4 + 13) & ~32'd1);
        emit(enc_i(12'h0, 5'd0, 3'h0, 5'd0, rv_pkg::OP_IMM));
        store_result(5'd5, jal_pc + 4);
        store_result(5'd7, jalr_pc + 4);
        finish_program();
        run_program();
        check_trace("control");
        check_results("control");
    endtask

    task automatic test_upper();
        logic [19:0] u1;
        logic [19:0] u2;
        logic [31:0] apc;
        new_program();
        u1 = $random(seed);
        u2 = $random(seed);
        emit_seq(enc_u(u1, 5'd1, rv_pkg::OP_LUI));
        store_result(5'd1, {u1, 12'd0});
        apc = 4 * prog_len;
        emit_seq(enc_u(u2, 5'd2, rv_pkg::OP_AUIPC));
        store_result(5'd2, apc + {u2, 12'd0});
        finish_program();
        run_program();
        check_results("upper");
    endtask

    initial begin
        seed = 32'hd248_3b5d;
        rst = 1'b1;
        instr = 32'h0000_0013;
        test_reset();
        test_arith();
        test_loads();
        test_stores();
        test_control();
        test_upper();
        $display("sim passed");
        $finish;
    end

endmodule

// File: vlog.f
src/rv_pkg.sv
src/main_decoder.sv
src/imm_gen.sv
src/alu.sv
src/reg_file.sv
src/commit_unit.sv
src/rv_core.sv
verif/tb_rv_core.sv

// File: Bender.yml
package:
  name: rv_core

sources:
  - src/rv_pkg.sv
  - src/main_decoder.sv
  - src/imm_gen.sv
  - src/alu.sv
  - src/reg_file.sv
  - src/commit_unit.sv
  - src/rv_core.sv
  - target: simulation
    files:
      - verif/tb_rv_core.sv
